// File: design/mac_mgnt_params.svh
`ifndef MAC_MGNT_PARAMS_SVH
`define MAC_MGNT_PARAMS_SVH

// register word and system port byte
`define MGNT_REG_W      32
`define MGNT_BYTE_W     8
`define MGNT_BYTES      4
`define MGNT_ADDR_W     8

// frame reports, flags above a 12-bit length
`define MGNT_LEN_W      12
`define RX_REPORT_W     20
`define TX_REPORT_W     16

// receive counters, read address equals index
`define MGNT_RX_CNT_N   10
`define RX_PKT          0
`define RX_BYTE         1
`define RX_VLAN         2
`define RX_LLDP         3
`define RX_1588         4
`define RX_TTE          5
`define RX_ERR_FCS      6
`define RX_ERR_RUNT     7
`define RX_ERR_JABR     8
`define RX_ERR_BP       9

// transmit counters, offsets from the base
`define MGNT_TX_CNT_N   6
`define TX_BASE         8'h10
`define TX_PKT          0
`define TX_BYTE         1
`define TX_TTE          2
`define TX_1588         3
`define TX_VLAN         4
`define TX_FC           5

// lldp register map
`define LLDP_REG_N      4
`define LLDP_MAC_LO     8'h80
`define LLDP_MAC_HI     8'h81
`define LLDP_PORT       8'h82
`define LLDP_MODE       8'h83
`define LLDP_FUNC       8'h8F
`define LLDP_FIELD_W    4
`define LLDP_MAC_W      48
`define LLDP_CONF_W     56

`endif

// File: design/mac_mgnt_pkg.sv
`default_nettype none

`include "mac_mgnt_params.svh"

package mac_mgnt_pkg;

    //////////////////////////////////////////////////
    // vectors
    //////////////////////////////////////////////////
    typedef logic [`MGNT_REG_W-1:0]  stat_cnt_t;
    typedef logic [`MGNT_ADDR_W-1:0] mgnt_addr_t;
    typedef logic [`MGNT_BYTE_W-1:0] mgnt_byte_t;

    // [19:12] flags, [11:0] length
    typedef logic [`RX_REPORT_W-1:0] rx_report_t;
    // [15:12] flags, [11:0] length
    typedef logic [`TX_REPORT_W-1:0] tx_report_t;

    // register banks
    typedef stat_cnt_t [`MGNT_RX_CNT_N-1:0] rx_stat_bank_t;
    typedef stat_cnt_t [`MGNT_TX_CNT_N-1:0] tx_stat_bank_t;
    typedef stat_cnt_t [`LLDP_REG_N-1:0]    lldp_bank_t;

    // {mode, port, mac}
    typedef logic [`LLDP_CONF_W-1:0] lldp_conf_t;

    //////////////////////////////////////////////////
    // state machines
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {IDLE, LOAD, SEND, RECV, COMMIT, ACK} mgnt_state_t;
    typedef enum logic [1:0] {WAIT, COUNT, HOLD} report_state_t;
    typedef enum logic {CONF_IDLE, CONF_REQ} conf_state_t;

endpackage

`default_nettype wire

// File: design/mgnt_reg_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_mgnt_params.svh"

module mgnt_reg_access
    import mac_mgnt_pkg::*;
(
    input  logic          clk_if,
    input  logic          rst_if,
    // command channel
    input  logic          sys_req_valid,
    input  logic          sys_req_wr,
    input  mgnt_addr_t    sys_req_addr,
    output logic          sys_req_ack,
    // write bytes
    input  mgnt_byte_t    sys_req_data,
    input  logic          sys_req_data_valid,
    // read bytes
    output mgnt_byte_t    sys_resp_data,
    output logic          sys_resp_data_valid,
    // register banks
    input  rx_stat_bank_t rx_stat,
    input  tx_stat_bank_t tx_stat,
    input  lldp_bank_t    lldp_regs,
    // write commit
    output logic          wr_stb,
    output mgnt_addr_t    wr_addr,
    output stat_cnt_t     wr_data
);

    localparam int CNT_W     = $clog2(`MGNT_BYTES);
    localparam int RX_IDX_W  = $clog2(`MGNT_RX_CNT_N);
    localparam int TX_IDX_W  = $clog2(`MGNT_TX_CNT_N);
    localparam int LL_IDX_W  = $clog2(`LLDP_REG_N);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`MGNT_BYTES - 1);
    localparam mgnt_addr_t RX_END = mgnt_addr_t'(`MGNT_RX_CNT_N);
    localparam mgnt_addr_t TX_END = mgnt_addr_t'(`TX_BASE + `MGNT_TX_CNT_N);

    mgnt_state_t        state_q, state_nxt;
    mgnt_addr_t         addr_q;
    logic [CNT_W-1:0]   byte_cnt;
    stat_cnt_t          data_q;
    stat_cnt_t          rd_word;
    mgnt_addr_t         tx_off;
    mgnt_addr_t         lldp_off;

    //////////////////////////////////////////////////
    // command fsm
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            IDLE:    if (sys_req_valid) state_nxt = sys_req_wr ? RECV : LOAD;
            LOAD:    state_nxt = SEND;
            SEND:    if (byte_cnt == LAST_BYTE) state_nxt = ACK;
            RECV:    if (sys_req_data_valid && byte_cnt == LAST_BYTE) state_nxt = COMMIT;
            COMMIT:  state_nxt = ACK;
            // host holds valid to stall here
            ACK:     if (!sys_req_valid) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            state_q <= IDLE;
            addr_q  <= '0;
        end else begin
            state_q <= state_nxt;
            if (state_q == IDLE && sys_req_valid) begin
                addr_q <= sys_req_addr;
            end
        end
    end

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////
    assign tx_off   = addr_q - `TX_BASE;
    assign lldp_off = addr_q - `LLDP_MAC_LO;

    always_comb begin
        rd_word = '0;
        if (addr_q < RX_END) begin
            rd_word = rx_stat[addr_q[RX_IDX_W-1:0]];
        end else if (addr_q >= `TX_BASE && addr_q < TX_END) begin
            rd_word = tx_stat[tx_off[TX_IDX_W-1:0]];
        end else if (addr_q >= `LLDP_MAC_LO && addr_q <= `LLDP_MODE) begin
            rd_word = lldp_regs[lldp_off[LL_IDX_W-1:0]];
        end
    end

    //////////////////////////////////////////////////
    // byte shifter, shared by read and write
    //////////////////////////////////////////////////
    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            byte_cnt <= '0;
            data_q   <= '0;
        end else begin
            case (state_q)
                LOAD: begin
                    byte_cnt <= '0;
                    data_q   <= rd_word;
                end
                SEND: begin
                    byte_cnt <= byte_cnt + CNT_W'(1);
                    data_q   <= data_q << `MGNT_BYTE_W;
                end
                RECV: begin
                    if (sys_req_data_valid) begin
                        byte_cnt <= byte_cnt + CNT_W'(1);
                        data_q   <= {data_q[`MGNT_REG_W-`MGNT_BYTE_W-1:0], sys_req_data};
                    end
                end
                default: byte_cnt <= '0;
            endcase
        end
    end

    // msb first
    assign sys_resp_data       = data_q[`MGNT_REG_W-1 -: `MGNT_BYTE_W];
    assign sys_resp_data_valid = (state_q == SEND);
    assign sys_req_ack         = (state_q == ACK);

    assign wr_stb  = (state_q == COMMIT);
    assign wr_addr = addr_q;
    assign wr_data = data_q;

endmodule

`default_nettype wire

// File: design/rx_frame_stats.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_mgnt_params.svh"

module rx_frame_stats
    import mac_mgnt_pkg::*;
(
    input  logic          clk_if,
    input  logic          rst_if,
    input  logic          rx_mgnt_valid,
    input  rx_report_t    rx_mgnt_data,
    output logic          rx_mgnt_resp,
    output rx_stat_bank_t rx_stat
);

    localparam stat_cnt_t ONE = stat_cnt_t'(1);

    logic [1:0]                 valid_sync;
    rx_report_t                 report_q;
    report_state_t              state_q, state_nxt;
    rx_stat_bank_t              cnt_q;
    logic [`MGNT_RX_CNT_N-1:0]  inc;
    logic                       resp_q;

    //////////////////////////////////////////////////
    // report handshake
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            WAIT:    if (valid_sync == 2'b11) state_nxt = COUNT;
            COUNT:   state_nxt = HOLD;
            HOLD:    if (!valid_sync[1]) state_nxt = WAIT;
            default: state_nxt = WAIT;
        endcase
    end

    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            valid_sync <= '0;
            state_q    <= WAIT;
            resp_q     <= 1'b0;
            report_q   <= '0;
        end else begin
            valid_sync <= {valid_sync[0], rx_mgnt_valid};
            state_q    <= state_nxt;
            resp_q     <= (state_nxt == HOLD);
            // data is stable once valid made it through both flops
            if (state_q == WAIT && valid_sync == 2'b11) begin
                report_q <= rx_mgnt_data;
            end
        end
    end

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////
    always_comb begin
        inc               = '0;
        // clean frame only when no error flag is set
        inc[`RX_PKT]      = (report_q[19:16] == 4'b0000);
        inc[`RX_ERR_BP]   = report_q[19];
        inc[`RX_ERR_JABR] = report_q[18];
        inc[`RX_ERR_RUNT] = report_q[17];
        inc[`RX_ERR_FCS]  = report_q[16];
        inc[`RX_TTE]      = report_q[15];
        inc[`RX_1588]     = report_q[14];
        inc[`RX_LLDP]     = report_q[13];
        inc[`RX_VLAN]     = report_q[12];
    end

    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            cnt_q <= '0;
        end else if (state_q == COUNT) begin
            for (int i = 0; i < `MGNT_RX_CNT_N; i++) begin
                if (inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + ONE;
                end
            end
            if (inc[`RX_PKT]) begin
                cnt_q[`RX_BYTE] <= cnt_q[`RX_BYTE] + stat_cnt_t'(report_q[`MGNT_LEN_W-1:0]);
            end
        end
    end

    assign rx_mgnt_resp = resp_q;
    assign rx_stat      = cnt_q;

endmodule

`default_nettype wire

// File: design/tx_frame_stats.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_mgnt_params.svh"

module tx_frame_stats
    import mac_mgnt_pkg::*;
(
    input  logic          clk_if,
    input  logic          rst_if,
    input  logic          tx_mgnt_valid,
    input  tx_report_t    tx_mgnt_data,
    output logic          tx_mgnt_resp,
    output tx_stat_bank_t tx_stat
);

    localparam stat_cnt_t ONE = stat_cnt_t'(1);

    logic [1:0]                 valid_sync;
    tx_report_t                 report_q;
    report_state_t              state_q, state_nxt;
    tx_stat_bank_t              cnt_q;
    logic [`MGNT_TX_CNT_N-1:0]  inc;
    logic                       resp_q;

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            WAIT:    if (valid_sync == 2'b11) state_nxt = COUNT;
            COUNT:   state_nxt = HOLD;
            HOLD:    if (!valid_sync[1]) state_nxt = WAIT;
            default: state_nxt = WAIT;
        endcase
    end

    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            valid_sync <= '0;
            state_q    <= WAIT;
            resp_q     <= 1'b0;
            report_q   <= '0;
        end else begin
            valid_sync <= {valid_sync[0], tx_mgnt_valid};
            state_q    <= state_nxt;
            resp_q     <= (state_nxt == HOLD);
            if (state_q == WAIT && valid_sync == 2'b11) begin
                report_q <= tx_mgnt_data;
            end
        end
    end

    // every transmit report is a sent frame
    always_comb begin
        inc          = '0;
        inc[`TX_PKT] = 1'b1;
        inc[`TX_TTE] = report_q[15];
        inc[`TX_1588] = report_q[14];
        inc[`TX_FC]  = report_q[13];
        inc[`TX_VLAN] = report_q[12];
    end

    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            cnt_q <= '0;
        end else if (state_q == COUNT) begin
            for (int i = 0; i < `MGNT_TX_CNT_N; i++) begin
                if (inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + ONE;
                end
            end
            cnt_q[`TX_BYTE] <= cnt_q[`TX_BYTE] + stat_cnt_t'(report_q[`MGNT_LEN_W-1:0]);
        end
    end

    assign tx_mgnt_resp = resp_q;
    assign tx_stat      = cnt_q;

endmodule

`default_nettype wire

// File: design/lldp_config.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_mgnt_params.svh"

module lldp_config
    import mac_mgnt_pkg::*;
(
    input  logic        clk_if,
    input  logic        rst_if,
    input  logic        wr_stb,
    input  mgnt_addr_t  wr_addr,
    input  stat_cnt_t   wr_data,
    output lldp_bank_t  lldp_regs,
    output logic        rx_conf_valid,
    input  logic        rx_conf_resp,
    output lldp_conf_t  rx_conf_data
);

    localparam int IDX_W    = $clog2(`LLDP_REG_N);
    localparam int LO_IDX   = `LLDP_MAC_LO - `LLDP_MAC_LO;
    localparam int HI_IDX   = `LLDP_MAC_HI - `LLDP_MAC_LO;
    localparam int PORT_IDX = `LLDP_PORT - `LLDP_MAC_LO;
    localparam int MODE_IDX = `LLDP_MODE - `LLDP_MAC_LO;

    lldp_bank_t  regs_q;
    mgnt_addr_t  reg_off;
    logic        reg_sel;
    logic        conf_trig;
    logic [1:0]  resp_sync;
    conf_state_t state_q, state_nxt;
    lldp_conf_t  conf_q;

    // address decode
    assign reg_off   = wr_addr - `LLDP_MAC_LO;
    assign reg_sel   = wr_stb && (wr_addr >= `LLDP_MAC_LO) && (wr_addr <= `LLDP_MODE);
    assign conf_trig = wr_stb && (wr_addr == `LLDP_FUNC);

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            CONF_IDLE: if (conf_trig) state_nxt = CONF_REQ;
            // receive path acks from its own clock
            CONF_REQ:  if (resp_sync == 2'b11) state_nxt = CONF_IDLE;
            default:   state_nxt = CONF_IDLE;
        endcase
    end

    always_ff @(posedge clk_if or negedge rst_if) begin
        if (!rst_if) begin
            regs_q    <= '0;
            resp_sync <= '0;
            state_q   <= CONF_IDLE;
            conf_q    <= '0;
        end else begin
            resp_sync <= {resp_sync[0], rx_conf_resp};
            state_q   <= state_nxt;
            if (reg_sel) begin
                regs_q[reg_off[IDX_W-1:0]] <= wr_data;
            end
            // snapshot so later writes leave the request alone
            if (state_q == CONF_IDLE && conf_trig) begin
                conf_q <= {regs_q[MODE_IDX][`LLDP_FIELD_W-1:0],
                           regs_q[PORT_IDX][`LLDP_FIELD_W-1:0],
                           regs_q[HI_IDX][`LLDP_MAC_W-`MGNT_REG_W-1:0],
                           regs_q[LO_IDX]};
            end
        end
    end

    assign lldp_regs     = regs_q;
    assign rx_conf_valid = (state_q == CONF_REQ);
    assign rx_conf_data  = conf_q;

endmodule

`default_nettype wire

// File: design/mac_mgnt_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_mgnt_params.svh"

module mac_mgnt_top
    import mac_mgnt_pkg::*;
(
    input  logic       clk_if,
    input  logic       rst_if,
    // receive path
    input  logic       rx_mgnt_valid,
    input  rx_report_t rx_mgnt_data,
    output logic       rx_mgnt_resp,
    output logic       rx_conf_valid,
    input  logic       rx_conf_resp,
    output lldp_conf_t rx_conf_data,
    // transmit path
    input  logic       tx_mgnt_valid,
    input  tx_report_t tx_mgnt_data,
    output logic       tx_mgnt_resp,
    // system port
    input  logic       sys_req_valid,
    input  logic       sys_req_wr,
    input  mgnt_addr_t sys_req_addr,
    output logic       sys_req_ack,
    input  mgnt_byte_t sys_req_data,
    input  logic       sys_req_data_valid,
    output mgnt_byte_t sys_resp_data,
    output logic       sys_resp_data_valid
);

    rx_stat_bank_t rx_stat;
    tx_stat_bank_t tx_stat;
    lldp_bank_t    lldp_regs;
    logic          wr_stb;
    mgnt_addr_t    wr_addr;
    stat_cnt_t     wr_data;

    mgnt_reg_access u_reg_access (
        .clk_if              (clk_if),
        .rst_if              (rst_if),
        .sys_req_valid       (sys_req_valid),
        .sys_req_wr          (sys_req_wr),
        .sys_req_addr        (sys_req_addr),
        .sys_req_ack         (sys_req_ack),
        .sys_req_data        (sys_req_data),
        .sys_req_data_valid  (sys_req_data_valid),
        .sys_resp_data       (sys_resp_data),
        .sys_resp_data_valid (sys_resp_data_valid),
        .rx_stat             (rx_stat),
        .tx_stat             (tx_stat),
        .lldp_regs           (lldp_regs),
        .wr_stb              (wr_stb),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data)
    );

    rx_frame_stats u_rx_stats (
        .clk_if        (clk_if),
        .rst_if        (rst_if),
        .rx_mgnt_valid (rx_mgnt_valid),
        .rx_mgnt_data  (rx_mgnt_data),
        .rx_mgnt_resp  (rx_mgnt_resp),
        .rx_stat       (rx_stat)
    );

    tx_frame_stats u_tx_stats (
        .clk_if        (clk_if),
        .rst_if        (rst_if),
        .tx_mgnt_valid (tx_mgnt_valid),
        .tx_mgnt_data  (tx_mgnt_data),
        .tx_mgnt_resp  (tx_mgnt_resp),
        .tx_stat       (tx_stat)
    );

    lldp_config u_lldp (
        .clk_if        (clk_if),
        .rst_if        (rst_if),
        .wr_stb        (wr_stb),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .lldp_regs     (lldp_regs),
        .rx_conf_valid (rx_conf_valid),
        .rx_conf_resp  (rx_conf_resp),
        .rx_conf_data  (rx_conf_data)
    );

endmodule

`default_nettype wire

// File: tests/mac_mgnt_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mac_mgnt_sva (
    input logic clk_if,
    input logic rst_if,
    input logic sys_resp_data_valid,
    input logic sys_req_ack,
    input logic rx_conf_valid,
    input logic rx_conf_resp
);

    // read bytes are done before the ack
    resp_ack_excl: assert property (@(posedge clk_if) disable iff (!rst_if)
        !(sys_resp_data_valid && sys_req_ack))
        else $error("read byte valid together with sys_req_ack");

    // request stays up until the receive path answers
    conf_hold: assert property (@(posedge clk_if) disable iff (!rst_if)
        (rx_conf_valid && !rx_conf_resp) |=> rx_conf_valid)
        else $error("rx_conf_valid dropped without rx_conf_resp");

endmodule

bind mac_mgnt_top mac_mgnt_sva u_sva (
    .clk_if              (clk_if),
    .rst_if              (rst_if),
    .sys_resp_data_valid (sys_resp_data_valid),
    .sys_req_ack         (sys_req_ack),
    .rx_conf_valid       (rx_conf_valid),
    .rx_conf_resp        (rx_conf_resp)
);

`default_nettype wire

// File: tests/tb_mac_mgnt.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_mgnt_params.svh"

module tb_mac_mgnt
    import mac_mgnt_pkg::*;
();

    // traffic is a few hundred reads, writes and reports of under 20 cycles each
    localparam int MAX_CYCLES = 20000;

    logic       clk_if;
    logic       rst_if;
    logic       rx_mgnt_valid;
    rx_report_t rx_mgnt_data;
    logic       rx_mgnt_resp;
    logic       rx_conf_valid;
    logic       rx_conf_resp;
    lldp_conf_t rx_conf_data;
    logic       tx_mgnt_valid;
    tx_report_t tx_mgnt_data;
    logic       tx_mgnt_resp;
    logic       sys_req_valid;
    logic       sys_req_wr;
    mgnt_addr_t sys_req_addr;
    logic       sys_req_ack;
    mgnt_byte_t sys_req_data;
    logic       sys_req_data_valid;
    mgnt_byte_t sys_resp_data;
    logic       sys_resp_data_valid;

    integer     seed = 19289;
    int         errors;
    int         checks;
    int         cycles;

    // scoreboard
    stat_cnt_t  rx_model [`MGNT_RX_CNT_N];
    stat_cnt_t  tx_model [`MGNT_TX_CNT_N];

    mac_mgnt_top DUT (.*);

    initial begin
        clk_if = 1'b0;
        forever #10 clk_if = ~clk_if;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_if);
            cycles++;
        end
        $display("Timeout: no end of run after %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_cnt(input string name, input stat_cnt_t exp, input stat_cnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_conf(input string name, input lldp_conf_t exp, input lldp_conf_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    //////////////////////////////////////////////////
    // system port drivers
    //////////////////////////////////////////////////
    task automatic sys_read(input mgnt_addr_t addr, output stat_cnt_t data);
        int nbytes;
        nbytes = 0;
        data   = '0;
        @(negedge clk_if);
        sys_req_valid = 1'b1;
        sys_req_wr    = 1'b0;
        sys_req_addr  = addr;
        @(negedge clk_if);
        while (!sys_req_ack) begin
            if (sys_resp_data_valid) begin
                data = {data[`MGNT_REG_W-`MGNT_BYTE_W-1:0], sys_resp_data};
                nbytes++;
            end
            @(negedge clk_if);
        end
        if (nbytes != `MGNT_BYTES) begin
            errors++;
            $display("read of address %02h gave %0d bytes instead of 4", addr, nbytes);
        end
        sys_req_valid = 1'b0;
        while (sys_req_ack) @(negedge clk_if);
    endtask

    // gapped inserts up to 3 idle cycles before each byte, hold keeps valid up after ack
    task automatic sys_write(input mgnt_addr_t addr, input stat_cnt_t data,
                             input bit gapped, input int hold);
        stat_cnt_t   word;
        logic [31:0] rnd;
        int          gap;
        word = data;
        @(negedge clk_if);
        sys_req_valid = 1'b1;
        sys_req_wr    = 1'b1;
        sys_req_addr  = addr;
        for (int i = 0; i < `MGNT_BYTES; i++) begin
            rnd = next_rand();
            gap = gapped ? int'(rnd[1:0]) : 0;
            repeat (gap) begin
                @(negedge clk_if);
                sys_req_data_valid = 1'b0;
            end
            @(negedge clk_if);
            sys_req_data       = word[`MGNT_REG_W-1 -: `MGNT_BYTE_W];
            sys_req_data_valid = 1'b1;
            word               = word << `MGNT_BYTE_W;
        end
        @(negedge clk_if);
        sys_req_data_valid = 1'b0;
        while (!sys_req_ack) @(negedge clk_if);
        repeat (hold) begin
            @(negedge clk_if);
            check_flag("ack held while valid high", 1'b1, sys_req_ack);
        end
        sys_req_valid = 1'b0;
        while (sys_req_ack) @(negedge clk_if);
    endtask

    task automatic read_and_compare(input mgnt_addr_t addr, input stat_cnt_t exp);
        stat_cnt_t act;
        sys_read(addr, act);
        check_cnt($sformatf("read %02h", addr), exp, act);
    endtask

    //////////////////////////////////////////////////
    // report drivers and count model
    //////////////////////////////////////////////////
    task automatic send_rx_report(input rx_report_t rep);
        @(negedge clk_if);
        rx_mgnt_data  = rep;
        rx_mgnt_valid = 1'b1;
        while (!rx_mgnt_resp) @(negedge clk_if);
        rx_mgnt_valid = 1'b0;
        while (rx_mgnt_resp) @(negedge clk_if);
        // clean frame when no error flag in 19:16
        if (rep[19:16] == 4'b0000) begin
            rx_model[`RX_PKT]  = rx_model[`RX_PKT] + 1;
            rx_model[`RX_BYTE] = rx_model[`RX_BYTE] + stat_cnt_t'(rep[11:0]);
        end
        if (rep[19]) rx_model[`RX_ERR_BP]   = rx_model[`RX_ERR_BP] + 1;
        if (rep[18]) rx_model[`RX_ERR_JABR] = rx_model[`RX_ERR_JABR] + 1;
        if (rep[17]) rx_model[`RX_ERR_RUNT] = rx_model[`RX_ERR_RUNT] + 1;
        if (rep[16]) rx_model[`RX_ERR_FCS]  = rx_model[`RX_ERR_FCS] + 1;
        if (rep[15]) rx_model[`RX_TTE]      = rx_model[`RX_TTE] + 1;
        if (rep[14]) rx_model[`RX_1588]     = rx_model[`RX_1588] + 1;
        if (rep[13]) rx_model[`RX_LLDP]     = rx_model[`RX_LLDP] + 1;
        if (rep[12]) rx_model[`RX_VLAN]     = rx_model[`RX_VLAN] + 1;
    endtask

    task automatic send_tx_report(input tx_report_t rep);
        @(negedge clk_if);
        tx_mgnt_data  = rep;
        tx_mgnt_valid = 1'b1;
        while (!tx_mgnt_resp) @(negedge clk_if);
        tx_mgnt_valid = 1'b0;
        while (tx_mgnt_resp) @(negedge clk_if);
        tx_model[`TX_PKT]  = tx_model[`TX_PKT] + 1;
        tx_model[`TX_BYTE] = tx_model[`TX_BYTE] + stat_cnt_t'(rep[11:0]);
        if (rep[15]) tx_model[`TX_TTE]  = tx_model[`TX_TTE] + 1;
        if (rep[14]) tx_model[`TX_1588] = tx_model[`TX_1588] + 1;
        if (rep[13]) tx_model[`TX_FC]   = tx_model[`TX_FC] + 1;
        if (rep[12]) tx_model[`TX_VLAN] = tx_model[`TX_VLAN] + 1;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic reset_state_test();
        check_flag("reset rx_mgnt_resp", 1'b0, rx_mgnt_resp);
        check_flag("reset tx_mgnt_resp", 1'b0, tx_mgnt_resp);
        check_flag("reset rx_conf_valid", 1'b0, rx_conf_valid);
        check_flag("reset sys_req_ack", 1'b0, sys_req_ack);
        check_flag("reset sys_resp_data_valid", 1'b0, sys_resp_data_valid);
        check_conf("reset rx_conf_data", '0, rx_conf_data);
        for (int i = 0; i < `MGNT_RX_CNT_N; i++) read_and_compare(mgnt_addr_t'(i), '0);
        for (int i = 0; i < `MGNT_TX_CNT_N; i++) read_and_compare(mgnt_addr_t'(`TX_BASE + i), '0);
        for (int i = 0; i < `LLDP_REG_N; i++) read_and_compare(mgnt_addr_t'(`LLDP_MAC_LO + i), '0);
    endtask

    task automatic rx_counter_test();
        logic [31:0] rnd;
        rx_report_t  rep;
        for (int n = 0; n < 30; n++) begin
            rnd = next_rand();
            rep = rnd[19:0];
            // about half the frames clean
            if (rnd[20]) rep[19:16] = 4'b0000;
            send_rx_report(rep);
        end
        for (int i = 0; i < `MGNT_RX_CNT_N; i++) read_and_compare(mgnt_addr_t'(i), rx_model[i]);
    endtask

    task automatic tx_counter_test();
        logic [31:0] rnd;
        for (int n = 0; n < 20; n++) begin
            rnd = next_rand();
            send_tx_report(rnd[15:0]);
        end
        for (int i = 0; i < `MGNT_TX_CNT_N; i++) begin
            read_and_compare(mgnt_addr_t'(`TX_BASE + i), tx_model[i]);
        end
    endtask

    task automatic lldp_config_test();
        stat_cnt_t  mac_lo;
        stat_cnt_t  mac_hi;
        stat_cnt_t  port_w;
        stat_cnt_t  mode_w;
        lldp_conf_t exp_conf;
        mac_lo = next_rand();
        mac_hi = next_rand();
        port_w = next_rand();
        mode_w = next_rand();
        sys_write(`LLDP_MAC_LO, mac_lo, 1'b0, 0);
        sys_write(`LLDP_MAC_HI, mac_hi, 1'b0, 0);
        sys_write(`LLDP_PORT, port_w, 1'b0, 0);
        sys_write(`LLDP_MODE, mode_w, 1'b0, 0);
        read_and_compare(`LLDP_MAC_LO, mac_lo);
        read_and_compare(`LLDP_MAC_HI, mac_hi);
        read_and_compare(`LLDP_PORT, port_w);
        read_and_compare(`LLDP_MODE, mode_w);
        // mode, port, 48-bit mac
        exp_conf = {mode_w[3:0], port_w[3:0], mac_hi[15:0], mac_lo};
        sys_write(`LLDP_FUNC, next_rand(), 1'b0, 0);
        check_flag("conf valid raised", 1'b1, rx_conf_valid);
        check_conf("conf data", exp_conf, rx_conf_data);
        repeat (6) begin
            @(negedge clk_if);
            check_flag("conf valid held before resp", 1'b1, rx_conf_valid);
        end
        rx_conf_resp = 1'b1;
        while (rx_conf_valid) @(negedge clk_if);
        rx_conf_resp = 1'b0;
        read_and_compare(`LLDP_FUNC, '0);
    endtask

    task automatic unmapped_access_test();
        read_and_compare(8'h40, '0);
        read_and_compare(8'h0A, '0);
        sys_write(mgnt_addr_t'(`RX_BYTE), 32'hDEAD_BEEF, 1'b0, 0);
        read_and_compare(mgnt_addr_t'(`RX_BYTE), rx_model[`RX_BYTE]);
        sys_write(mgnt_addr_t'(`TX_BASE + `TX_PKT), 32'h1234_5678, 1'b0, 0);
        read_and_compare(mgnt_addr_t'(`TX_BASE + `TX_PKT), tx_model[`TX_PKT]);
    endtask

    task automatic gapped_write_test();
        logic [31:0] rnd;
        stat_cnt_t   word;
        mgnt_addr_t  addr;
        for (int n = 0; n < 4; n++) begin
            rnd  = next_rand();
            word = next_rand();
            addr = mgnt_addr_t'(`LLDP_MAC_LO + int'(rnd[1:0]));
            sys_write(addr, word, 1'b1, 3 + n);
            read_and_compare(addr, word);
        end
    endtask

    initial begin
        errors             = 0;
        checks             = 0;
        rst_if             = 1'b0;
        rx_mgnt_valid      = 1'b0;
        rx_mgnt_data       = '0;
        rx_conf_resp       = 1'b0;
        tx_mgnt_valid      = 1'b0;
        tx_mgnt_data       = '0;
        sys_req_valid      = 1'b0;
        sys_req_wr         = 1'b0;
        sys_req_addr       = '0;
        sys_req_data       = '0;
        sys_req_data_valid = 1'b0;
        for (int i = 0; i < `MGNT_RX_CNT_N; i++) rx_model[i] = '0;
        for (int i = 0; i < `MGNT_TX_CNT_N; i++) tx_model[i] = '0;
        repeat (10) @(negedge clk_if);
        rst_if = 1'b1;
        reset_state_test();
        rx_counter_test();
        tx_counter_test();
        lldp_config_test();
        unmapped_access_test();
        gapped_write_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/mac_mgnt_pkg.sv
design/mgnt_reg_access.sv
design/rx_frame_stats.sv
design/tx_frame_stats.sv
design/lldp_config.sv
design/mac_mgnt_top.sv
tests/mac_mgnt_sva.sv
tests/tb_mac_mgnt.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f vlog.f --top-module tb_mac_mgnt -o tb_mac_mgnt
	./obj_dir/tb_mac_mgnt | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
